// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --timing --assert
TOP       := tb_fetch_top
FILELIST  := sim.f
OBJ_DIR   := obj_dir
RUN_FLAGS := +verilator+error+limit+100
PASS_TEXT := Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== fetch_asserts.sv ====
`timescale 1ns/1ps

module fetch_asserts (
    input logic                  clk,
    input logic                  rst,
    input logic                  arvalid,
    input logic                  arready,
    input fetch_pkg::axi_ar_t    ar,
    input logic                  ifu_valid,
    input logic                  idu_ready,
    input fetch_pkg::fetch_pkt_t fetch_pkt
);
    import fetch_pkg::*;

    int failures;

    // request must not move while the slave stalls
    ar_stable: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar))
        else begin
            $error("arvalid dropped or ar changed before arready");
            failures = failures + 1;
        end

    burst_len: assert property (@(posedge clk) disable iff (rst)
        arvalid && ar.len == 8'd3 |-> ar.burst == BURST_INCR)
        else begin
            $error("len 3 request without an INCR burst");
            failures = failures + 1;
        end

    pkt_hold: assert property (@(posedge clk) disable iff (rst)
        ifu_valid && !idu_ready |=> ifu_valid && $stable(fetch_pkt))
        else begin
            $error("fetch packet changed while decode stalled");
            failures = failures + 1;
        end

    no_early_valid: assert property (@(posedge clk) $fell(rst) |=> !ifu_valid)
        else begin
            $error("ifu_valid high right after reset release");
            failures = failures + 1;
        end

endmodule

bind fetch_top fetch_asserts i_asserts (
    .clk       (clk),
    .rst       (rst),
    .arvalid   (arvalid),
    .arready   (arready),
    .ar        (ar),
    .ifu_valid (ifu_valid),
    .idu_ready (idu_ready),
    .fetch_pkt (fetch_pkt)
);

// ==== fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// first fetch address out of reset
`define FETCH_RESET_PC 32'h3000_0000

// one cache line is four 32-bit words
`define LINE_BYTES 16
`define LINE_WORDS (`LINE_BYTES / 4)

// direct-mapped, one line per index
`define ICACHE_LINES 16

// burst-capable memory window
`define SDRAM_BASE 32'hA000_0000
`define SDRAM_END  32'hBFFF_FFFF

// AXI read response and transfer size
`define AXI_RESP_OKAY 2'b00
`define AXI_SIZE_WORD 3'd2

`endif

// ==== fetch_pkg.sv ====
`include "fetch_macros.svh"

package fetch_pkg;

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        BUSY = 2'b01, // AXI refill in flight
        READ = 2'b10  // line written, packet pending
    } ifu_state_t;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01
    } axi_burst_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        fault;
    } fetch_pkt_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        axi_burst_t  burst;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
        logic [3:0]  id;
    } axi_r_t;

    // word 0 sits in the low bits
    typedef struct packed {
        logic [`LINE_BYTES*8-1:0] data;
        logic                     fault;
    } line_fill_t;

endpackage

// ==== fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  redirect_valid,
    input  logic [31:0]           redirect_pc,
    input  logic                  idu_ready,
    output logic                  ifu_valid,
    output fetch_pkg::fetch_pkt_t fetch_pkt,
    output logic                  access_fault,
    output logic                  arvalid,
    input  logic                  arready,
    output fetch_pkg::axi_ar_t    ar,
    input  logic                  rvalid,
    output logic                  rready,
    input  fetch_pkg::axi_r_t     r
);
    import fetch_pkg::*;

    // cache port
    logic [31:0] cache_pc;
    logic        cache_hit;
    logic [31:0] cache_word;
    logic        miss_req;
    logic        fill_valid;
    line_fill_t  fill;

    ifu i_ifu (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .idu_ready      (idu_ready),
        .ifu_valid      (ifu_valid),
        .fetch_pkt      (fetch_pkt),
        .access_fault   (access_fault),
        .arvalid        (arvalid),
        .arready        (arready),
        .ar             (ar),
        .rvalid         (rvalid),
        .rready         (rready),
        .r              (r),
        .cache_pc       (cache_pc),
        .cache_hit      (cache_hit),
        .cache_word     (cache_word),
        .miss_req       (miss_req),
        .fill_valid     (fill_valid),
        .fill           (fill)
    );

    icache i_icache (
        .clk        (clk),
        .rst        (rst),
        .addr       (cache_pc),
        .hit        (cache_hit),
        .word       (cache_word),
        .miss_req   (miss_req),
        .fill_valid (fill_valid),
        .fill       (fill)
    );

endmodule

// ==== icache.sv ====
`timescale 1ns/1ps
`include "fetch_macros.svh"

module icache (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [31:0]           addr,
    output logic                  hit,
    output logic [31:0]           word,
    output logic                  miss_req,
    input  logic                  fill_valid,
    input  fetch_pkg::line_fill_t fill
);

    localparam int OFFS_W = $clog2(`LINE_BYTES);
    localparam int IDX_W  = $clog2(`ICACHE_LINES);
    localparam int TAG_W  = 32 - IDX_W - OFFS_W;
    localparam int WSEL_W = OFFS_W - 2;

    // per-line storage
    logic [TAG_W-1:0]                 tag_mem  [`ICACHE_LINES];
    logic [`LINE_WORDS-1:0][31:0]     data_mem [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0]         valid_q;

    // address split
    logic [TAG_W-1:0]  addr_tag;
    logic [IDX_W-1:0]  addr_idx;
    logic [WSEL_W-1:0] addr_wsel;

    logic                         line_valid;
    logic [TAG_W-1:0]             line_tag;
    logic [`LINE_WORDS-1:0][31:0] line_data;
    logic                         fill_wr;

    assign addr_tag  = addr[31 -: TAG_W];
    assign addr_idx  = addr[OFFS_W +: IDX_W];
    assign addr_wsel = addr[2 +: WSEL_W];

    // combinational lookup
    always_comb begin
        line_valid = valid_q[addr_idx];
        line_tag   = tag_mem[addr_idx];
        line_data  = data_mem[addr_idx];
    end

    assign hit      = line_valid && (line_tag == addr_tag);
    assign miss_req = !hit;
    assign word     = line_data[addr_wsel];

    // faulted refills never land in the array
    assign fill_wr = fill_valid && !fill.fault;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill_wr) begin
            valid_q[addr_idx] <= 1'b1;
        end
    end

    // pc is held during refill, so addr still names the missing line
    always_ff @(posedge clk) begin
        if (fill_wr) begin
            tag_mem[addr_idx]  <= addr_tag;
            data_mem[addr_idx] <= fill.data;
        end
    end

endmodule

// ==== ifu.sv ====
`timescale 1ns/1ps
`include "fetch_macros.svh"

module ifu (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  redirect_valid,
    input  logic [31:0]           redirect_pc,
    input  logic                  idu_ready,
    output logic                  ifu_valid,
    output fetch_pkg::fetch_pkt_t fetch_pkt,
    output logic                  access_fault,
    output logic                  arvalid,
    input  logic                  arready,
    output fetch_pkg::axi_ar_t    ar,
    input  logic                  rvalid,
    output logic                  rready,
    input  fetch_pkg::axi_r_t     r,
    output logic [31:0]           cache_pc,
    input  logic                  cache_hit,
    input  logic [31:0]           cache_word,
    input  logic                  miss_req,
    output logic                  fill_valid,
    output fetch_pkg::line_fill_t fill
);
    import fetch_pkg::*;

    localparam int OFFS_W = $clog2(`LINE_BYTES);
    localparam int BEAT_W = OFFS_W - 2;
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`LINE_WORDS - 1);

    ifu_state_t        state;
    ifu_state_t        next_state;
    logic [31:0]       pc;
    logic [31:0]       dnpc;
    logic [31:0]       line_base;
    logic [BEAT_W-1:0] beat_cnt;

    logic is_sdram;
    logic pc_advance;
    logic start_refill;
    logic r_fire;
    logic r_err;
    logic last_beat;
    logic r_done;
    logic next_single;
    logic rd_fault;

    assign cache_pc  = pc;
    assign dnpc      = redirect_valid ? redirect_pc : pc + 32'd4;
    assign line_base = {pc[31:OFFS_W], {OFFS_W{1'b0}}};
    assign is_sdram  = (line_base >= `SDRAM_BASE) && (line_base <= `SDRAM_END);

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (idu_ready && !cache_hit) begin
                    next_state = BUSY;
                end
            end
            BUSY: begin
                if (fill_valid) begin
                    next_state = READ;
                end
            end
            READ: begin
                if (idu_ready) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // pc moves whenever a packet is issued, hit or post-refill
    assign pc_advance   = (next_state == IDLE) && idu_ready;
    assign start_refill = (state == IDLE) && idu_ready && miss_req;

    // refill beat bookkeeping
    assign r_fire      = (state == BUSY) && rvalid && rready;
    assign r_err       = r_fire && (r.resp != `AXI_RESP_OKAY);
    assign last_beat   = is_sdram ? r.last : (beat_cnt == LAST_BEAT);
    assign r_done      = r_fire && !r_err && last_beat;
    assign next_single = r_fire && !r_err && !last_beat && !is_sdram;

    assign rd_fault = (state == READ) && fill.fault;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= IDLE;
            pc           <= `FETCH_RESET_PC;
            ifu_valid    <= 1'b0;
            arvalid      <= 1'b0;
            rready       <= 1'b0;
            fill_valid   <= 1'b0;
            access_fault <= 1'b0;
            beat_cnt     <= '0;
        end else begin
            state        <= next_state;
            fill_valid   <= r_done || r_err; // one-cycle pulses
            access_fault <= r_err;

            if (pc_advance) begin
                pc        <= dnpc;
                ifu_valid <= !redirect_valid; // drop on redirect
            end else if (idu_ready) begin
                ifu_valid <= 1'b0;
            end

            if (start_refill) begin
                arvalid  <= 1'b1;
                beat_cnt <= '0;
            end else if (arvalid && arready) begin
                arvalid <= 1'b0;
                rready  <= 1'b1;
            end else if (r_fire) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (r_err || r_done || next_single) begin
                    rready <= 1'b0;
                end
                if (next_single) begin
                    arvalid <= 1'b1;
                end
            end
        end
    end

    // packet, AR payload and line buffer
    always_ff @(posedge clk) begin
        if (pc_advance && !redirect_valid) begin
            fetch_pkt.pc    <= pc;
            fetch_pkt.inst  <= (cache_hit && !rd_fault) ? cache_word : 32'd0;
            fetch_pkt.fault <= rd_fault;
        end

        if (start_refill) begin
            ar.addr    <= line_base;
            ar.id      <= 4'd0;
            ar.size    <= `AXI_SIZE_WORD;
            ar.len     <= is_sdram ? 8'(`LINE_WORDS - 1) : 8'd0;
            ar.burst   <= is_sdram ? BURST_INCR : BURST_FIXED;
            fill.fault <= 1'b0;
        end else if (next_single) begin
            ar.addr <= {line_base[31:OFFS_W], beat_cnt + 1'b1, 2'b00};
        end

        if (r_fire) begin
            if (r_err) begin
                fill.fault <= 1'b1;
            end else begin
                fill.data[beat_cnt*32 +: 32] <= r.data;
            end
        end
    end

endmodule

// ==== sim.f ====
+incdir+.
fetch_pkg.sv
icache.sv
ifu.sv
fetch_top.sv
tb_axi_mem.sv
fetch_asserts.sv
tb_fetch_top.sv

// ==== tb_axi_mem.sv ====
`timescale 1ns/1ps

module tb_axi_mem (
    input  logic               clk,
    input  logic               rst,
    input  logic               arvalid,
    output logic               arready,
    input  fetch_pkg::axi_ar_t ar,
    output logic               rvalid,
    input  logic               rready,
    output fetch_pkg::axi_r_t  r
);
    import fetch_pkg::*;

    int          ar_count;    // every AR handshake
    int          burst_count; // handshakes with len above zero
    axi_ar_t     last_ar;

    logic        busy;
    logic        ar_seen;     // request already waited one cycle
    logic [31:0] beat_addr;
    logic [31:0] next_addr;
    logic [7:0]  beats_left;
    axi_burst_t  burst_q;
    logic [3:0]  id_q;

    // data is address xor pattern and the error window answers SLVERR
    function automatic axi_r_t read_beat(input logic [31:0] a, input logic [3:0] id,
                                         input logic last);
        axi_r_t b;
        b.data = a ^ 32'h5A5A_5A5A;
        b.resp = 2'b00;
        if (a >= 32'h3000_0100 && a <= 32'h3000_010F) begin
            b.resp = 2'b10;
        end
        b.last = last;
        b.id   = id;
        return b;
    endfunction

    // one request at a time and each one stalls a cycle
    assign arready   = !busy && ar_seen;
    assign next_addr = (burst_q == BURST_INCR) ? beat_addr + 32'd4 : beat_addr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ar_seen <= 1'b0;
        end else begin
            ar_seen <= arvalid && !busy && !ar_seen;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy        <= 1'b0;
            rvalid      <= 1'b0;
            r           <= '0;
            ar_count    <= 0;
            burst_count <= 0;
            last_ar     <= '0;
            beat_addr   <= '0;
            beats_left  <= '0;
            burst_q     <= BURST_FIXED;
            id_q        <= '0;
        end else if (arvalid && arready) begin
            busy        <= 1'b1;
            rvalid      <= 1'b1;
            ar_count    <= ar_count + 1;
            if (ar.len != 8'd0) begin
                burst_count <= burst_count + 1;
            end
            last_ar    <= ar;
            beat_addr  <= ar.addr;
            beats_left <= ar.len;
            burst_q    <= ar.burst;
            id_q       <= ar.id;
            r          <= read_beat(ar.addr, ar.id, ar.len == 8'd0);
        end else if (rvalid && rready) begin
            if (beats_left == 8'd0) begin
                busy   <= 1'b0;
                rvalid <= 1'b0;
            end else begin
                beat_addr  <= next_addr;
                beats_left <= beats_left - 8'd1;
                r          <= read_beat(next_addr, id_q, beats_left == 8'd1);
            end
        end
    end

endmodule

// ==== tb_fetch_top.sv ====
`timescale 1ns/1ps

module tb_fetch_top;
    import fetch_pkg::*;

    localparam int PKT_TIMEOUT = 200;

    logic        clk;
    logic        rst;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        idu_ready;
    logic        ifu_valid;
    fetch_pkt_t  fetch_pkt;
    logic        access_fault;
    logic        arvalid;
    logic        arready;
    axi_ar_t     ar;
    logic        rvalid;
    logic        rready;
    axi_r_t      r;

    logic [7:0]  lfsr;
    int          errors;
    int          checks;
    int          test_errors;
    int          tests_run;
    int          fault_pulses;
    bit          timed_out;

    fetch_top i_dut (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .idu_ready      (idu_ready),
        .ifu_valid      (ifu_valid),
        .fetch_pkt      (fetch_pkt),
        .access_fault   (access_fault),
        .arvalid        (arvalid),
        .arready        (arready),
        .ar             (ar),
        .rvalid         (rvalid),
        .rready         (rready),
        .r              (r)
    );

    tb_axi_mem i_mem (
        .clk     (clk),
        .rst     (rst),
        .arvalid (arvalid),
        .arready (arready),
        .ar      (ar),
        .rvalid  (rvalid),
        .rready  (rready),
        .r       (r)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (rst) begin
            fault_pulses <= 0;
        end else if (access_fault) begin
            fault_pulses <= fault_pulses + 1;
        end
    end

    // galois form, x^8+x^6+x^5+x^4+1
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        if (timed_out) begin
            return;
        end
        checks++;
        if (exp !== act) begin
            errors++;
            test_errors++;
            $display("MISMATCH %s %s: expected %08h, actual %08h", test, what, exp, act);
        end
    endtask

    // waits for the next accepted packet, optionally redirecting on that edge
    task automatic take_packet(input string test, input logic [31:0] exp_pc,
                               input bit random_ready, input bit redirect,
                               input logic [31:0] target);
        int         waited;
        bit         accepted;
        bit         exp_fault;
        fetch_pkt_t pkt;
        waited   = 0;
        accepted = 1'b0;
        pkt      = '0;
        while (!accepted && !timed_out) begin
            if (random_ready) begin
                idu_ready = lfsr[0];
                lfsr      = lfsr_step(lfsr);
            end else begin
                idu_ready = 1'b1;
            end
            accepted = ifu_valid && idu_ready;
            if (accepted) begin
                pkt            = fetch_pkt;
                redirect_valid = redirect;
                redirect_pc    = target;
            end else if (waited == PKT_TIMEOUT) begin
                timed_out = 1'b1;
                $display("timeout: %s got no packet for pc %08h in %0d cycles",
                         test, exp_pc, waited);
            end
            waited++;
            next_cycle();
        end
        redirect_valid = 1'b0;
        exp_fault = (exp_pc >= 32'h3000_0100) && (exp_pc <= 32'h3000_010F);
        check_value(test, "pc", exp_pc, pkt.pc);
        check_value(test, "inst", exp_fault ? 32'd0 : (exp_pc ^ 32'h5A5A_5A5A), pkt.inst);
        check_value(test, "fault", 32'(exp_fault), 32'(pkt.fault));
    endtask

    task automatic take_run(input string test, input logic [31:0] first_pc,
                            input int count, input bit random_ready);
        for (int i = 0; i < count; i++) begin
            take_packet(test, first_pc + 32'(4 * i), random_ready, 1'b0, 32'd0);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("%s: %s, %0d errors", name, timed_out ? "stopped" : "done", test_errors);
        test_errors = 0;
    endtask

    task automatic test_reset_fetch();
        take_run("reset_fetch", 32'h3000_0000, 4, 1'b0);
        check_value("reset_fetch", "ar count", 32'd4, i_mem.ar_count);
        check_value("reset_fetch", "burst count", 32'd0, i_mem.burst_count);
        end_test("reset_fetch");
    endtask

    task automatic test_cache_reuse();
        int base;
        // packet at 30000010 comes from the refill started after test 1
        take_packet("cache_reuse", 32'h3000_0010, 1'b0, 1'b1, 32'h3000_0000);
        base = i_mem.ar_count;
        take_run("cache_reuse", 32'h3000_0000, 4, 1'b0);
        check_value("cache_reuse", "new ar", 32'd0, i_mem.ar_count - base);
        end_test("cache_reuse");
    endtask

    task automatic test_sdram_burst();
        int ars;
        int bursts;
        ars    = i_mem.ar_count;
        bursts = i_mem.burst_count;
        take_packet("sdram_burst", 32'h3000_0010, 1'b0, 1'b1, 32'hA000_0040);
        take_run("sdram_burst", 32'hA000_0040, 4, 1'b0);
        check_value("sdram_burst", "ar count", 32'd1, i_mem.ar_count - ars);
        check_value("sdram_burst", "burst count", 32'd1, i_mem.burst_count - bursts);
        check_value("sdram_burst", "ar addr", 32'hA000_0040, i_mem.last_ar.addr);
        check_value("sdram_burst", "ar len", 32'd3, 32'(i_mem.last_ar.len));
        check_value("sdram_burst", "ar burst", 32'(BURST_INCR), 32'(i_mem.last_ar.burst));
        end_test("sdram_burst");
    endtask

    task automatic test_redirect_drop();
        take_packet("redirect_drop", 32'hA000_0050, 1'b0, 1'b1, 32'h3000_0008);
        check_value("redirect_drop", "valid after redirect", 32'd0, 32'(ifu_valid));
        take_packet("redirect_drop", 32'h3000_0008, 1'b0, 1'b0, 32'd0);
        end_test("redirect_drop");
    endtask

    task automatic test_backpressure();
        // crosses into the 30000020 and 30000030 lines
        take_run("backpressure", 32'h3000_000C, 11, 1'b1);
        end_test("backpressure");
    endtask

    task automatic test_access_fault();
        int ars;
        int faults;
        ars    = i_mem.ar_count;
        faults = fault_pulses;
        take_packet("access_fault", 32'h3000_0038, 1'b0, 1'b1, 32'h3000_0100);
        take_packet("access_fault", 32'h3000_0100, 1'b0, 1'b0, 32'd0);
        check_value("access_fault", "ar count", 32'd1, i_mem.ar_count - ars);
        check_value("access_fault", "fault pulses", 32'd1, fault_pulses - faults);
        take_run("access_fault", 32'h3000_0104, 3, 1'b0);
        take_packet("access_fault", 32'h3000_0110, 1'b0, 1'b1, 32'h3000_0100);
        ars = i_mem.ar_count;
        take_packet("access_fault", 32'h3000_0100, 1'b0, 1'b0, 32'd0);
        check_value("access_fault", "refetch ar count", 32'd1, i_mem.ar_count - ars);
        end_test("access_fault");
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = 32'd0;
        idu_ready      = 1'b0;
        lfsr           = 8'd91;
        errors         = 0;
        checks         = 0;
        test_errors    = 0;
        tests_run      = 0;
        timed_out      = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset_fetch();
        test_cache_reuse();
        test_sdram_burst();
        test_redirect_drop();
        test_backpressure();
        test_access_fault();

        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d, timeout %0d",
                 tests_run, checks, errors, i_dut.i_asserts.failures, timed_out);
        if (errors == 0 && !timed_out && i_dut.i_asserts.failures == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
